// ==== logic/pov_consts.svh ====
// Display geometry and timing constants for the LED column display
`ifndef POV_CONSTS_SVH
`define POV_CONSTS_SVH

`default_nettype none

// Serial data lanes into the driver chains
`define POV_LANES 4
// Bits shifted into each lane per column
`define POV_LANE_BITS 16
// Columns in one frame
`define POV_COLS 8
// Full column word, lanes times lane bits
`define POV_COL_BITS 64
// System clocks per shift tick
`define POV_SHIFT_DIV 4

`default_nettype wire
`endif

// ==== logic/pov_pkg.sv ====
// Package with SPI opcodes, decoder and sequencer states, column word type
`include "pov_consts.svh"
`default_nettype none

package pov_pkg;

    // First byte of every SPI frame
    typedef enum logic [7:0] {
        OP_WRITE_COL   = 8'h10,
        OP_SET_ENABLE  = 8'h20,
        OP_READ_STATUS = 8'h30
    } spi_opcode_e;

    typedef enum logic [2:0] {
        DEC_OPCODE,
        DEC_INDEX,
        DEC_DATA,
        DEC_ENABLE,
        DEC_IGNORE
    } dec_state_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_SHIFT,
        SEQ_LATCH
    } seq_state_e;

    // Lane k occupies bits (k+1)*16-1 downto k*16
    typedef logic [`POV_COL_BITS-1:0] col_word_t;

endpackage

`default_nettype wire

// ==== logic/spi_frame_rx.sv ====
// Mode-0 SPI slave: pin synchronizers, byte assembly and reply shift-out
`default_nettype none

module spi_frame_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_sclk,
    input  logic       spi_cs_n,
    input  logic       spi_mosi,
    output logic       spi_miso,
    input  logic [7:0] tx_byte,
    output logic [7:0] rx_byte,
    output logic       byte_valid,
    output logic       frame_start
);

    // Two sync flops plus one history flop for edge detection
    logic [2:0] sclk_pipe;
    logic [2:0] cs_pipe;
    logic [1:0] mosi_pipe;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_fall;
    logic       cs_high;
    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;

    assign sclk_rise = sclk_pipe[1] & ~sclk_pipe[2];
    assign sclk_fall = ~sclk_pipe[1] & sclk_pipe[2];
    assign cs_fall   = ~cs_pipe[1] & cs_pipe[2];
    assign cs_high   = cs_pipe[1];
    assign rx_byte   = rx_shift;
    // MSB of the reply goes out first
    assign spi_miso  = tx_shift[7];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sclk_pipe <= '0;
            cs_pipe   <= '1;
            mosi_pipe <= '0;
        end else begin
            sclk_pipe <= {sclk_pipe[1:0], spi_sclk};
            cs_pipe   <= {cs_pipe[1:0], spi_cs_n};
            mosi_pipe <= {mosi_pipe[0], spi_mosi};
        end
    end

    // MOSI sampled on rising SPI clock, aligned with the delayed edge
    always_ff @(posedge clk) begin
        if (sclk_rise && !cs_high) begin
            rx_shift <= {rx_shift[6:0], mosi_pipe[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt     <= '0;
            byte_valid  <= 1'b0;
            frame_start <= 1'b0;
            tx_shift    <= '0;
        end else begin
            byte_valid  <= 1'b0;
            frame_start <= cs_fall;
            if (cs_high) begin
                // Deselect drops any partial byte
                bit_cnt  <= '0;
                tx_shift <= '0;
            end else begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        byte_valid <= 1'b1;
                    end
                end
                // Falling edge at a byte boundary picks up the next reply
                if (sclk_fall) begin
                    if (bit_cnt == 3'd0) begin
                        tx_shift <= tx_byte;
                    end else begin
                        tx_shift <= {tx_shift[6:0], 1'b0};
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/command_decoder.sv ====
// Frame decoder with column memory, enable flag and status reply
`include "pov_consts.svh"
`default_nettype none

module command_decoder (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [7:0]                          rx_byte,
    input  logic                                byte_valid,
    input  logic                                frame_start,
    output logic [7:0]                          tx_byte,
    input  logic [$clog2(`POV_COLS)-1:0]        col_addr,
    output pov_pkg::col_word_t                  col_data,
    input  logic [7:0]                          frame_count,
    output logic                                display_enable
);

    localparam int COL_AW     = $clog2(`POV_COLS);
    localparam int DATA_BYTES = `POV_COL_BITS / 8;
    localparam int BYTE_W     = $clog2(DATA_BYTES);

    pov_pkg::dec_state_e state;
    pov_pkg::col_word_t  col_mem [`POV_COLS];
    pov_pkg::col_word_t  stage;
    logic [COL_AW-1:0]   wr_idx;
    logic [BYTE_W-1:0]   byte_cnt;
    logic                last_byte;
    logic                mem_we;

    // Read port for the scan, no latency
    assign col_data  = col_mem[col_addr];
    assign last_byte = byte_cnt == BYTE_W'(DATA_BYTES - 1);
    assign mem_we    = byte_valid && state == pov_pkg::DEC_DATA && last_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `POV_COLS; i++) begin
                col_mem[i] <= '0;
            end
        end else if (mem_we) begin
            col_mem[wr_idx] <= {stage[`POV_COL_BITS-9:0], rx_byte};
        end
    end

    // Staging word, most significant byte arrives first
    always_ff @(posedge clk) begin
        if (byte_valid && state == pov_pkg::DEC_DATA) begin
            stage <= {stage[`POV_COL_BITS-9:0], rx_byte};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= pov_pkg::DEC_OPCODE;
            wr_idx         <= '0;
            byte_cnt       <= '0;
            display_enable <= 1'b0;
            tx_byte        <= '0;
        end else if (frame_start) begin
            state   <= pov_pkg::DEC_OPCODE;
            tx_byte <= '0;
        end else if (byte_valid) begin
            // Reply only in the byte right after a status opcode
            tx_byte <= '0;
            case (state)
                pov_pkg::DEC_OPCODE: begin
                    case (rx_byte)
                        pov_pkg::OP_WRITE_COL:  state <= pov_pkg::DEC_INDEX;
                        pov_pkg::OP_SET_ENABLE: state <= pov_pkg::DEC_ENABLE;
                        pov_pkg::OP_READ_STATUS: begin
                            // Snapshot frame count at the opcode
                            tx_byte <= frame_count;
                            state   <= pov_pkg::DEC_IGNORE;
                        end
                        default: state <= pov_pkg::DEC_IGNORE;
                    endcase
                end
                pov_pkg::DEC_INDEX: begin
                    wr_idx   <= rx_byte[COL_AW-1:0];
                    byte_cnt <= '0;
                    state    <= pov_pkg::DEC_DATA;
                end
                pov_pkg::DEC_DATA: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    // Word written by mem_we, trailing bytes dropped
                    if (last_byte) begin
                        state <= pov_pkg::DEC_IGNORE;
                    end
                end
                pov_pkg::DEC_ENABLE: begin
                    display_enable <= rx_byte[0];
                    state          <= pov_pkg::DEC_IGNORE;
                end
                default: state <= pov_pkg::DEC_IGNORE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/column_timer.sv ====
// Shift tick divider and free-running grayscale clock
`include "pov_consts.svh"
`default_nettype none

module column_timer (
    input  logic clk,
    input  logic rst_n,
    output logic shift_tick,
    output logic gclk
);

    localparam int DIV_W = (`POV_SHIFT_DIV > 1) ? $clog2(`POV_SHIFT_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            shift_tick <= 1'b0;
            gclk       <= 1'b0;
        end else begin
            // One-cycle tick every POV_SHIFT_DIV clocks
            if (div_cnt == DIV_W'(`POV_SHIFT_DIV - 1)) begin
                div_cnt    <= '0;
                shift_tick <= 1'b1;
            end else begin
                div_cnt    <= div_cnt + 1'b1;
                shift_tick <= 1'b0;
            end
            // Grayscale clock runs regardless of enable
            if (shift_tick) begin
                gclk <= ~gclk;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/driver_sequencer.sv ====
// Column scan FSM: load, shift pacing, latch, column select, frame count
`include "pov_consts.svh"
`default_nettype none

module driver_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         shift_tick,
    input  logic                         display_enable,
    output logic [$clog2(`POV_COLS)-1:0] col_addr,
    output logic                         load,
    output logic                         shift,
    output logic                         sclk,
    output logic                         lat,
    output logic [`POV_COLS-1:0]         col_sel,
    output logic [7:0]                   frame_count
);

    localparam int COL_AW = $clog2(`POV_COLS);
    localparam int BIT_AW = $clog2(`POV_LANE_BITS);
    localparam logic [`POV_COLS-1:0] SEL_ONE = {{(`POV_COLS-1){1'b0}}, 1'b1};

    pov_pkg::seq_state_e state;
    logic [BIT_AW-1:0]   bit_cnt;
    logic                last_bit;
    logic                last_col;

    assign last_bit = bit_cnt == BIT_AW'(`POV_LANE_BITS - 1);
    assign last_col = col_addr == COL_AW'(`POV_COLS - 1);
    // Shifter captures col_data during the single LOAD cycle
    assign load     = state == pov_pkg::SEQ_LOAD;
    // Driver clock high only in the tick cycle
    assign sclk     = (state == pov_pkg::SEQ_SHIFT) && shift_tick;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= pov_pkg::SEQ_IDLE;
            bit_cnt     <= '0;
            col_addr    <= '0;
            shift       <= 1'b0;
            lat         <= 1'b0;
            col_sel     <= '0;
            frame_count <= '0;
        end else begin
            // Data moves the cycle after sclk, so sin holds through it
            shift <= sclk;
            lat   <= 1'b0;
            case (state)
                pov_pkg::SEQ_IDLE: begin
                    col_sel <= '0;
                    if (display_enable && shift_tick) begin
                        state <= pov_pkg::SEQ_LOAD;
                    end
                end
                pov_pkg::SEQ_LOAD: begin
                    bit_cnt <= '0;
                    state   <= pov_pkg::SEQ_SHIFT;
                end
                pov_pkg::SEQ_SHIFT: begin
                    if (shift_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state <= pov_pkg::SEQ_LATCH;
                        end
                    end
                end
                pov_pkg::SEQ_LATCH: begin
                    if (shift_tick) begin
                        // Latch and column select change together
                        lat     <= 1'b1;
                        col_sel <= SEL_ONE << col_addr;
                        if (last_col) begin
                            frame_count <= frame_count + 8'd1;
                        end
                        // Disable takes effect only here, at a column boundary
                        if (display_enable) begin
                            col_addr <= last_col ? '0 : col_addr + 1'b1;
                            state    <= pov_pkg::SEQ_LOAD;
                        end else begin
                            col_addr <= '0;
                            state    <= pov_pkg::SEQ_IDLE;
                        end
                    end
                end
                default: state <= pov_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/column_shifter.sv ====
// Column word shift register feeding the serial lanes MSB first
`include "pov_consts.svh"
`default_nettype none

module column_shifter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pov_pkg::col_word_t     col_data,
    input  logic                   load,
    input  logic                   shift,
    output logic [`POV_LANES-1:0]  sin
);

    localparam int LB = `POV_LANE_BITS;

    pov_pkg::col_word_t word_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_q <= '0;
        end else if (load) begin
            word_q <= col_data;
        end else if (shift) begin
            // Each lane moves up one, zero fills from the bottom
            for (int k = 0; k < `POV_LANES; k++) begin
                word_q[k*LB +: LB] <= {word_q[k*LB +: LB-1], 1'b0};
            end
        end
    end

    // Top bit of every lane is on the pin
    always_comb begin
        for (int k = 0; k < `POV_LANES; k++) begin
            sin[k] = word_q[(k+1)*LB-1];
        end
    end

endmodule

`default_nettype wire

// ==== logic/pov_display_top.sv ====
// Top level: SPI slave, decoder, timer, sequencer and shifter to display pins
`include "pov_consts.svh"
`default_nettype none

module pov_display_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // Host SPI
    input  logic                  som_sclk,
    input  logic                  som_cs_n,
    input  logic                  som_mosi,
    output logic                  som_miso,
    // LED driver chains
    output logic                  drv_sclk,
    output logic                  drv_lat,
    output logic                  drv_gclk,
    output logic [`POV_LANES-1:0] drv_sin,
    // Column multiplexer
    output logic [`POV_COLS-1:0]  col_sel
);

    // SPI byte stream
    logic [7:0] rx_byte;
    logic [7:0] tx_byte;
    logic       byte_valid;
    logic       frame_start;

    // Scan side
    logic [$clog2(`POV_COLS)-1:0] col_addr;
    pov_pkg::col_word_t           col_data;
    logic [7:0]                   frame_count;
    logic                         display_enable;
    logic                         shift_tick;
    logic                         load;
    logic                         shift;

    spi_frame_rx u_spi_frame_rx (
        .clk(clk), .rst_n(rst_n),
        .spi_sclk(som_sclk), .spi_cs_n(som_cs_n),
        .spi_mosi(som_mosi), .spi_miso(som_miso),
        .tx_byte(tx_byte), .rx_byte(rx_byte),
        .byte_valid(byte_valid), .frame_start(frame_start)
    );

    command_decoder u_command_decoder (
        .clk(clk), .rst_n(rst_n),
        .rx_byte(rx_byte), .byte_valid(byte_valid),
        .frame_start(frame_start), .tx_byte(tx_byte),
        .col_addr(col_addr), .col_data(col_data),
        .frame_count(frame_count), .display_enable(display_enable)
    );

    column_timer u_column_timer (
        .clk(clk), .rst_n(rst_n),
        .shift_tick(shift_tick), .gclk(drv_gclk)
    );

    driver_sequencer u_driver_sequencer (
        .clk(clk), .rst_n(rst_n),
        .shift_tick(shift_tick), .display_enable(display_enable),
        .col_addr(col_addr), .load(load), .shift(shift),
        .sclk(drv_sclk), .lat(drv_lat), .col_sel(col_sel),
        .frame_count(frame_count)
    );

    column_shifter u_column_shifter (
        .clk(clk), .rst_n(rst_n),
        .col_data(col_data), .load(load), .shift(shift),
        .sin(drv_sin)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Free-running testbench clock source
`default_nettype none

module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period, starts low
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== testbench/pov_display_assertions.sv ====
// Concurrent assertions on the driver sequencer outputs, bound into driver_sequencer
`include "pov_consts.svh"
`default_nettype none

module pov_display_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 load,
    input logic                 sclk,
    input logic                 lat,
    input logic [`POV_COLS-1:0] col_sel
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failure tally, read by the testbench top
    int fail_count = 0;

    // Latch never overlaps a driver clock
    a_lat_sclk_excl: assert property (@(posedge clk) disable iff (!rst_n) !(lat && sclk))
        else begin
            $error("lat and sclk high in the same cycle");
            fail_count++;
        end

    // Latch is a single-cycle pulse
    a_lat_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) lat |=> !lat)
        else begin
            $error("lat held high for more than one cycle");
            fail_count++;
        end

    // At most one column driven, and it moves only with the latch or clears
    a_col_sel_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(col_sel) && ($stable(col_sel) || lat || col_sel == '0))
        else begin
            $error("col_sel not one-hot or changed without a latch");
            fail_count++;
        end

    // Driver clock stays on the tick grid, one tick after the load or the previous clock
    a_sclk_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
        sclk |-> $past(sclk, `POV_SHIFT_DIV) || $past(load, `POV_SHIFT_DIV - 1))
        else begin
            $error("sclk high outside a shift tick");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== testbench/pov_display_tb.sv ====
// Testbench top: SPI frame table, driver pin capture, scan checks and summary
`include "pov_consts.svh"
`default_nettype none

module pov_display_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SPI_HALF  = 4;
    localparam int NUM_STEPS = 16;
    localparam int LB        = `POV_LANE_BITS;
    // Reply field value meaning the frame count seen on the pins
    localparam logic [15:0] FROM_FRAMES = 16'hFFFF;

    typedef struct packed {
        logic [7:0]  op;
        logic [7:0]  arg;
        logic [15:0] exp_reply;
    } step_t;

    logic                  clk;
    logic                  rst_n;
    logic                  som_sclk;
    logic                  som_cs_n;
    logic                  som_mosi;
    logic                  som_miso;
    logic                  drv_sclk;
    logic                  drv_lat;
    logic                  drv_gclk;
    logic [`POV_LANES-1:0] drv_sin;
    logic [`POV_COLS-1:0]  col_sel;

    step_t              steps [NUM_STEPS];
    // Mirror of the column memory
    pov_pkg::col_word_t model [`POV_COLS];
    logic [7:0]         frame_buf [10];
    logic [7:0]         reply_buf [10];
    logic [LB-1:0]      lane_acc [`POV_LANES];
    logic [15:0]        lfsr;
    int                 errors;
    int                 checks;
    int                 lat_count;
    int                 frames_seen;
    int                 next_col;
    int                 sclk_cnt;
    bit                 timed_out;

    tb_clock_gen u_tb_clock_gen (.clk(clk));

    pov_display_top u_pov_display_top (
        .clk(clk), .rst_n(rst_n),
        .som_sclk(som_sclk), .som_cs_n(som_cs_n),
        .som_mosi(som_mosi), .som_miso(som_miso),
        .drv_sclk(drv_sclk), .drv_lat(drv_lat), .drv_gclk(drv_gclk),
        .drv_sin(drv_sin), .col_sel(col_sel)
    );

    bind driver_sequencer pov_display_assertions u_pov_display_assertions (
        .clk(clk), .rst_n(rst_n), .load(load),
        .sclk(sclk), .lat(lat), .col_sel(col_sel)
    );

    task automatic check_word(input string name, input pov_pkg::col_word_t got,
                              input pov_pkg::col_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_col(input string name, input logic [`POV_COLS-1:0] got,
                             input logic [`POV_COLS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Lands 2 ns after a rising edge
    task automatic cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // Mode 0, MSB first, MISO sampled as the clock rises
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            som_mosi = tx[i];
            cycles(SPI_HALF);
            rx[i] = som_miso;
            som_sclk = 1'b1;
            cycles(SPI_HALF);
            som_sclk = 1'b0;
        end
    endtask

    task automatic spi_frame(input int len);
        som_cs_n = 1'b0;
        cycles(SPI_HALF);
        for (int i = 0; i < len; i++) begin
            spi_byte(frame_buf[i], reply_buf[i]);
        end
        cycles(SPI_HALF);
        som_cs_n = 1'b1;
        cycles(2 * SPI_HALF);
    endtask

    // Columns: opcode, column index or enable bit, expected status reply
    task automatic load_table();
        steps[0] = {pov_pkg::OP_READ_STATUS, 8'h00, 16'h0000};
        for (int i = 0; i < `POV_COLS; i++) begin
            steps[1 + i] = {pov_pkg::OP_WRITE_COL, 8'(i), 16'h0000};
        end
        steps[9]  = {pov_pkg::OP_SET_ENABLE, 8'h01, 16'h0000};
        steps[10] = {pov_pkg::OP_SET_ENABLE, 8'h00, 16'h0000};
        steps[11] = {pov_pkg::OP_READ_STATUS, 8'h00, FROM_FRAMES};
        // Unknown opcode with a full payload behind it
        steps[12] = {8'h5A, 8'h03, 16'h0000};
        steps[13] = {pov_pkg::OP_SET_ENABLE, 8'h01, 16'h0000};
        steps[14] = {pov_pkg::OP_SET_ENABLE, 8'h00, 16'h0000};
        steps[15] = {pov_pkg::OP_READ_STATUS, 8'h00, FROM_FRAMES};
    endtask

    // Disabled display keeps driver pins quiet while gclk keeps running
    task automatic idle_check();
        int                   pulses;
        int                   toggles;
        logic                 gclk_prev;
        logic [`POV_COLS-1:0] sel_seen;
        pulses   = 0;
        toggles  = 0;
        sel_seen = '0;
        @(negedge clk);
        gclk_prev = drv_gclk;
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            if (drv_lat || drv_sclk) begin
                pulses++;
            end
            if (drv_gclk !== gclk_prev) begin
                toggles++;
            end
            gclk_prev = drv_gclk;
            sel_seen = sel_seen | col_sel;
        end
        check_col("col_sel", sel_seen, '0);
        // One gclk edge per shift tick
        check_byte("drv_gclk toggles", 8'(toggles), 8'(200 / `POV_SHIFT_DIV));
        checks++;
        if (pulses != 0) begin
            errors++;
            $display("drv_lat or drv_sclk pulsed %0d times while disabled", pulses);
        end
        cycles(1);
    endtask

    task automatic wait_lats(input int n);
        int target;
        int waited;
        target = lat_count + n;
        waited = 0;
        while (lat_count < target && waited < 100 * n + 200) begin
            @(posedge clk);
            waited++;
        end
        #2;
        if (lat_count < target) begin
            $display("timeout: only %0d of %0d latch pulses arrived", n - (target - lat_count), n);
            timed_out = 1'b1;
        end
    endtask

    // Scan counts as stopped after 150 cycles without a latch
    task automatic wait_scan_stop();
        int quiet;
        int waited;
        int last;
        quiet  = 0;
        waited = 0;
        last   = lat_count;
        while (quiet < 150 && waited < 2000) begin
            @(posedge clk);
            waited++;
            if (lat_count != last) begin
                last  = lat_count;
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        #2;
        if (quiet < 150) begin
            $display("timeout: scan kept running after the display was disabled");
            timed_out = 1'b1;
        end
    endtask

    // Rebuild the column word from lane samples at each latch
    task automatic scan_column();
        pov_pkg::col_word_t   word;
        logic [`POV_COLS-1:0] exp_sel;
        int                   col;
        col = 0;
        for (int k = 0; k < `POV_LANES; k++) begin
            word[k*LB +: LB] = lane_acc[k];
        end
        for (int c = 0; c < `POV_COLS; c++) begin
            if (col_sel[c]) begin
                col = c;
            end
        end
        exp_sel = `POV_COLS'(1) << next_col;
        check_col("col_sel", col_sel, exp_sel);
        check_word("drv_sin word", word, model[col]);
        check_byte("drv_sclk count", 8'(sclk_cnt), 8'(LB));
        // Last column closes a frame
        if (col_sel[`POV_COLS-1]) begin
            frames_seen++;
        end
        next_col  = (next_col + 1) % `POV_COLS;
        lat_count++;
        sclk_cnt  = 0;
    endtask

    // Pins sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (drv_sclk) begin
                for (int k = 0; k < `POV_LANES; k++) begin
                    lane_acc[k] = {lane_acc[k][LB-2:0], drv_sin[k]};
                end
                sclk_cnt++;
            end
            if (drv_lat) begin
                scan_column();
            end
        end
    end

    initial begin
        step_t              s;
        pov_pkg::col_word_t w;
        logic [7:0]         b;
        logic [7:0]         exp_reply;
        logic               unknown_op;
        int                 len;
        int                 err_before;
        int                 assert_fails;
        som_sclk    = 1'b0;
        som_cs_n    = 1'b1;
        som_mosi    = 1'b0;
        rst_n       = 1'b0;
        errors      = 0;
        checks      = 0;
        lat_count   = 0;
        frames_seen = 0;
        next_col    = 0;
        sclk_cnt    = 0;
        timed_out   = 1'b0;
        lfsr        = 16'd38;
        w           = '0;
        for (int c = 0; c < `POV_COLS; c++) begin
            model[c] = '0;
        end
        load_table();
        cycles(16);
        rst_n = 1'b1;
        cycles(2);

        err_before = errors;
        idle_check();
        $display("test idle: %s", (errors == err_before) ? "ok" : "FAILED");

        for (int t = 0; t < NUM_STEPS && !timed_out; t++) begin
            s          = steps[t];
            err_before = errors;
            unknown_op = s.op != pov_pkg::OP_WRITE_COL && s.op != pov_pkg::OP_SET_ENABLE
                         && s.op != pov_pkg::OP_READ_STATUS;
            frame_buf[0] = s.op;
            frame_buf[1] = s.arg;
            len = 2;
            if (s.op == pov_pkg::OP_WRITE_COL || unknown_op) begin
                for (int i = 0; i < 8; i++) begin
                    random_byte(b);
                    frame_buf[2 + i] = b;
                    w = {w[`POV_COL_BITS-9:0], b};
                end
                len = 10;
            end
            if (s.op == pov_pkg::OP_WRITE_COL) begin
                model[s.arg[2:0]] = w;
            end
            // Fresh scan starts at column 0
            if (s.op == pov_pkg::OP_SET_ENABLE && s.arg[0]) begin
                next_col = 0;
            end
            spi_frame(len);
            if (s.op == pov_pkg::OP_READ_STATUS) begin
                exp_reply = (s.exp_reply == FROM_FRAMES) ? 8'(frames_seen) : s.exp_reply[7:0];
                check_byte("som_miso reply", reply_buf[1], exp_reply);
            end else if (s.op == pov_pkg::OP_SET_ENABLE) begin
                if (s.arg[0]) begin
                    wait_lats(2 * `POV_COLS);
                end else begin
                    wait_scan_stop();
                end
            end
            $display("step %0d op %h arg %h: %s", t, s.op, s.arg,
                     (errors == err_before && !timed_out) ? "ok" : "FAILED");
        end

        cycles(4);
        assert_fails = u_pov_display_top.u_driver_sequencer.u_pov_display_assertions.fail_count;
        errors = errors + assert_fails;
        $display("checks %0d, errors %0d, assertion failures %0d, frames %0d",
                 checks, errors, assert_fails, frames_seen);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/pov_pkg.sv
logic/spi_frame_rx.sv
logic/command_decoder.sv
logic/column_timer.sv
logic/driver_sequencer.sv
logic/column_shifter.sv
logic/pov_display_top.sv
testbench/tb_clock_gen.sv
testbench/pov_display_assertions.sv
testbench/pov_display_tb.sv

// ==== Bender.yml ====
package:
  name: pov_display

export_include_dirs:
  - logic

sources:
  - logic/pov_pkg.sv
  - logic/spi_frame_rx.sv
  - logic/command_decoder.sv
  - logic/column_timer.sv
  - logic/driver_sequencer.sv
  - logic/column_shifter.sv
  - logic/pov_display_top.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/pov_display_assertions.sv
      - testbench/pov_display_tb.sv
